// File: source/dsp_width_pkg.sv
package dsp_width_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Sample widths
    ////////////////////////////////////////////////////////////////////////////

    // A and D samples, signed
    localparam int A_W = 26;

    // Preadder sum carries one extra bit so D + A never wraps
    localparam int PREADD_W = A_W + 1;

    // Coefficient, signed
    localparam int B_W = 18;

    ////////////////////////////////////////////////////////////////////////////
    // Datapath widths
    ////////////////////////////////////////////////////////////////////////////

    // Full signed product of the preadder sum and the coefficient
    localparam int PROD_W = PREADD_W + B_W;

    // Accumulator width, shared by C, PCIN and P
    localparam int P_W = 48;

    // Sign bits added when the product is widened to the accumulator
    localparam int PROD_EXT_W = P_W - PROD_W;

endpackage

// File: source/dsp_cfg_pkg.sv
package dsp_cfg_pkg;

    import dsp_width_pkg::*;

    ////////////////////////////////////////////////////////////////////////////
    // ALU configuration
    ////////////////////////////////////////////////////////////////////////////

    // C is subtracted, done as ~C plus a carry of one
    localparam bit SUBTRACT_C = 1'b1;

    ////////////////////////////////////////////////////////////////////////////
    // Pattern detect
    ////////////////////////////////////////////////////////////////////////////

    // Value that the compared bits of P must equal
    localparam logic [P_W-1:0] PATTERN_VAL = '0;

    // A one marks a compared bit, only the low nibble here
    localparam logic [P_W-1:0] MASK_VAL = 48'h0000_0000_000F;

    ////////////////////////////////////////////////////////////////////////////
    // Pipeline depths, in clock edges from sampling to P
    ////////////////////////////////////////////////////////////////////////////

    // Input register, multiplier register, P register
    localparam int PIPE_AD = 3;

    // C register, P register
    localparam int PIPE_C = 2;

    // PCIN feeds the final adder directly
    localparam int PIPE_PCIN = 1;

endpackage

// File: source/product_path.sv
`timescale 1ns/1ps

module product_path
    import dsp_width_pkg::*;
(
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic signed [A_W-1:0] a_i,
    input  logic signed [A_W-1:0] d_i,
    input  logic [B_W-1:0]        b_i,
    input  logic                  load_i,
    input  logic                  update_i,
    output logic [P_W-1:0]        product_o
);

    logic signed [A_W-1:0]      a_q;
    logic signed [A_W-1:0]      d_q;
    logic [B_W-1:0]             b_stage_q;
    logic [B_W-1:0]             b_active_q;
    logic signed [PREADD_W-1:0] preadd;
    logic signed [PROD_W-1:0]   mult;
    logic [P_W-1:0]             product_q;

    ////////////////////////////////////////////////////////////////////////////
    // Input registers
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            a_q <= '0;
            d_q <= '0;
        end else begin
            a_q <= a_i;
            d_q <= d_i;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Two-stage coefficient store
    ////////////////////////////////////////////////////////////////////////////

    // Update moves the staged value held before this edge, so a
    // simultaneous load only reaches the active register next time
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            b_stage_q  <= '0;
            b_active_q <= '0;
        end else begin
            if (load_i) begin
                b_stage_q <= b_i;
            end
            if (update_i) begin
                b_active_q <= b_stage_q;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Preadder and multiplier
    ////////////////////////////////////////////////////////////////////////////

    // Sign-extend both samples by one bit to keep the carry
    assign preadd = {d_q[A_W-1], d_q} + {a_q[A_W-1], a_q};

    // 27 x 18 signed, the full product fits in PROD_W bits
    assign mult = preadd * $signed(b_active_q);

    // Multiplier register, widened to the accumulator
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            product_q <= '0;
        end else begin
            product_q <= {{PROD_EXT_W{mult[PROD_W-1]}}, mult};
        end
    end

    assign product_o = product_q;

endmodule

// File: source/addend_path.sv
`timescale 1ns/1ps

module addend_path
    import dsp_width_pkg::*;
    import dsp_cfg_pkg::*;
(
    input  logic           clk_i,
    input  logic           rst_n_i,
    input  logic [P_W-1:0] c_i,
    input  logic [P_W-1:0] pcin_i,
    output logic [P_W-1:0] addend_o,
    output logic           carry_o
);

    logic [P_W-1:0] c_q;
    logic [P_W-1:0] c_eff;

    ////////////////////////////////////////////////////////////////////////////
    // C register
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            c_q <= '0;
        end else begin
            c_q <= c_i;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Addend
    ////////////////////////////////////////////////////////////////////////////

    // One's complement of C when subtracting
    assign c_eff = SUBTRACT_C ? ~c_q : c_q;

    // PCIN joins unregistered, it lands in P on the next edge
    assign addend_o = c_eff + pcin_i;

    // Plus one finishes the two's complement of C
    assign carry_o = SUBTRACT_C ? 1'b1 : 1'b0;

endmodule

// File: source/post_adder.sv
`timescale 1ns/1ps

module post_adder
    import dsp_width_pkg::*;
    import dsp_cfg_pkg::*;
(
    input  logic           clk_i,
    input  logic           rst_n_i,
    input  logic [P_W-1:0] product_i,
    input  logic [P_W-1:0] addend_i,
    input  logic           carry_i,
    output logic [P_W-1:0] p_o,
    output logic           pattern_o
);

    logic [P_W-1:0] sum;
    logic           match;
    logic [P_W-1:0] p_q;
    logic           pattern_q;

    ////////////////////////////////////////////////////////////////////////////
    // Final adder
    ////////////////////////////////////////////////////////////////////////////

    // Wraps modulo 2^P_W like the hardware accumulator
    assign sum = product_i + addend_i + P_W'(carry_i);

    ////////////////////////////////////////////////////////////////////////////
    // Pattern detect
    ////////////////////////////////////////////////////////////////////////////

    // Compare on the sum itself so the flag lines up with P
    assign match = ((sum ^ PATTERN_VAL) & MASK_VAL) == '0;

    ////////////////////////////////////////////////////////////////////////////
    // P register
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            p_q       <= '0;
            pattern_q <= 1'b0;
        end else begin
            p_q       <= sum;
            pattern_q <= match;
        end
    end

    assign p_o       = p_q;
    assign pattern_o = pattern_q;

endmodule

// File: source/dsp_slice_top.sv
`timescale 1ns/1ps

module dsp_slice_top
    import dsp_width_pkg::*;
(
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    // Preadder samples
    input  logic signed [A_W-1:0] a_i,
    input  logic signed [A_W-1:0] d_i,
    // Coefficient load
    input  logic [B_W-1:0]        b_i,
    input  logic                  load_i,
    input  logic                  update_i,
    // Accumulator operands
    input  logic [P_W-1:0]        c_i,
    input  logic [P_W-1:0]        pcin_i,
    // Result
    output logic [P_W-1:0]        p_o,
    output logic                  pattern_o
);

    logic [P_W-1:0] product;
    logic [P_W-1:0] addend;
    logic           carry;

    // (D + A) x B, two edges deep
    product_path u_product_path (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .a_i       (a_i),
        .d_i       (d_i),
        .b_i       (b_i),
        .load_i    (load_i),
        .update_i  (update_i),
        .product_o (product)
    );

    // PCIN - C, one edge deep for C
    addend_path u_addend_path (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .c_i      (c_i),
        .pcin_i   (pcin_i),
        .addend_o (addend),
        .carry_o  (carry)
    );

    post_adder u_post_adder (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .product_i (product),
        .addend_i  (addend),
        .carry_i   (carry),
        .p_o       (p_o),
        .pattern_o (pattern_o)
    );

endmodule

// File: tb/dsp_checker.sv
`timescale 1ns/1ps

module dsp_checker
    import dsp_width_pkg::*;
    import dsp_cfg_pkg::*;
(
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic signed [A_W-1:0] a_i,
    input  logic signed [A_W-1:0] d_i,
    input  logic [B_W-1:0]        b_i,
    input  logic                  load_i,
    input  logic                  update_i,
    input  logic [P_W-1:0]        c_i,
    input  logic [P_W-1:0]        pcin_i,
    input  logic [P_W-1:0]        p_i,
    input  logic                  pattern_i,
    input  logic                  report_i,
    output int                    p_errors_o,
    output int                    pattern_errors_o,
    output int                    checks_o
);

    // Operands seen at the last PIPE_* edges with index 0 the newest
    logic signed [A_W-1:0] a_line [PIPE_AD];
    logic signed [A_W-1:0] d_line [PIPE_AD];
    logic [B_W-1:0]        coef_line [PIPE_AD];
    logic [P_W-1:0]        c_line [PIPE_C];
    logic [P_W-1:0]        pcin_line [PIPE_PCIN];

    logic [B_W-1:0]        staged;
    logic [B_W-1:0]        active;
    logic [P_W-1:0]        exp_p;
    logic                  exp_pattern;
    bit                    armed = 1'b0;
    int                    p_errors = 0;
    int                    pattern_errors = 0;
    int                    checks = 0;
    int                    pattern_hits = 0;

    ////////////////////////////////////////////////////////////////////////////
    // Reference arithmetic
    ////////////////////////////////////////////////////////////////////////////

    // Plain 64-bit integer math reduced to the accumulator width at the end
    function automatic logic [P_W-1:0] expected_result(
        input logic signed [A_W-1:0] a,
        input logic signed [A_W-1:0] d,
        input logic [B_W-1:0]        coef,
        input logic [P_W-1:0]        c,
        input logic [P_W-1:0]        pcin
    );
        longint      sum_ad;
        longint      coef_s;
        longint      prod;
        logic [63:0] total;
        sum_ad = longint'(a) + longint'(d);
        coef_s = longint'($signed(coef));
        prod   = sum_ad * coef_s;
        total  = prod;
        if (SUBTRACT_C) begin
            total = total - {{(64-P_W){1'b0}}, c};
        end else begin
            total = total + {{(64-P_W){1'b0}}, c};
        end
        total = total + {{(64-P_W){1'b0}}, pcin};
        return total[P_W-1:0];
    endfunction

    task automatic clear_model();
        for (int i = 0; i < PIPE_AD; i++) begin
            a_line[i]    = '0;
            d_line[i]    = '0;
            coef_line[i] = '0;
        end
        for (int i = 0; i < PIPE_C; i++) begin
            c_line[i] = '0;
        end
        for (int i = 0; i < PIPE_PCIN; i++) begin
            pcin_line[i] = '0;
        end
        staged      = '0;
        active      = '0;
        exp_p       = '0;
        exp_pattern = 1'b0;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Model update on every rising edge
    ////////////////////////////////////////////////////////////////////////////

    always @(posedge clk_i) begin
        if (!rst_n_i) begin
            clear_model();
            armed = 1'b1;
        end else begin
            // Update takes the staged value from before this edge's load
            if (update_i) begin
                active = staged;
            end
            if (load_i) begin
                staged = b_i;
            end
            for (int i = PIPE_AD - 1; i > 0; i--) begin
                a_line[i]    = a_line[i-1];
                d_line[i]    = d_line[i-1];
                coef_line[i] = coef_line[i-1];
            end
            a_line[0]    = a_i;
            d_line[0]    = d_i;
            coef_line[0] = active;
            for (int i = PIPE_C - 1; i > 0; i--) begin
                c_line[i] = c_line[i-1];
            end
            c_line[0] = c_i;
            for (int i = PIPE_PCIN - 1; i > 0; i--) begin
                pcin_line[i] = pcin_line[i-1];
            end
            pcin_line[0] = pcin_i;
            exp_p = expected_result(a_line[PIPE_AD-1], d_line[PIPE_AD-1],
                                    coef_line[PIPE_AD-1], c_line[PIPE_C-1],
                                    pcin_line[PIPE_PCIN-1]);
            exp_pattern = ((exp_p & MASK_VAL) == (PATTERN_VAL & MASK_VAL));
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Comparison half a cycle after the edge
    ////////////////////////////////////////////////////////////////////////////

    always @(negedge clk_i) begin
        if (armed) begin
            checks++;
            if (p_i !== exp_p) begin
                p_errors++;
                $display("ERROR p_o expected 0x%h actual 0x%h at %0t ns", exp_p, p_i, $time);
            end
            if (pattern_i !== exp_pattern) begin
                pattern_errors++;
                $display("ERROR pattern_o expected 0x%h actual 0x%h at %0t ns",
                         exp_pattern, pattern_i, $time);
            end
            if (exp_pattern) begin
                pattern_hits++;
            end
        end
    end

    always @(posedge report_i) begin
        $display("Checks %0d, p_o errors %0d, pattern_o errors %0d, pattern hits %0d",
                 checks, p_errors, pattern_errors, pattern_hits);
    end

    assign p_errors_o       = p_errors;
    assign pattern_errors_o = pattern_errors;
    assign checks_o         = checks;

endmodule

// File: tb/tb_dsp_slice.sv
`timescale 1ns/1ps

module tb_dsp_slice
    import dsp_width_pkg::*;
    import dsp_cfg_pkg::*;
();

    localparam int CLK_HALF       = 10;
    localparam int RESET_CYCLES   = 5;
    localparam int NUM_CYCLES     = 2000;
    localparam int SEED           = 2401;
    localparam int TIMEOUT_CYCLES = NUM_CYCLES + RESET_CYCLES + PIPE_AD + 50;

    // Phase boundaries in stimulus cycles
    localparam int ZERO_END      = 16;
    localparam int COEF_END      = 40;
    localparam int EXTREME_START = 1400;
    localparam int EXTREME_END   = 1600;
    localparam int QUIET_END     = 1800;

    localparam logic [A_W-1:0] A_MAX = {1'b0, {(A_W-1){1'b1}}};
    localparam logic [A_W-1:0] A_MIN = {1'b1, {(A_W-1){1'b0}}};
    localparam logic [B_W-1:0] B_MAX = {1'b0, {(B_W-1){1'b1}}};
    localparam logic [B_W-1:0] B_MIN = {1'b1, {(B_W-1){1'b0}}};

    logic                  clk;
    logic                  rst_n;
    logic signed [A_W-1:0] a;
    logic signed [A_W-1:0] d;
    logic [B_W-1:0]        b;
    logic                  load;
    logic                  update;
    logic [P_W-1:0]        c;
    logic [P_W-1:0]        pcin;
    logic [P_W-1:0]        p;
    logic                  pattern;
    logic                  report;
    int                    p_errors;
    int                    pattern_errors;
    int                    checks;
    int                    cycle_count = 0;

    always #(CLK_HALF) clk = ~clk;

    dsp_slice_top DUT (
        .clk_i     (clk),
        .rst_n_i   (rst_n),
        .a_i       (a),
        .d_i       (d),
        .b_i       (b),
        .load_i    (load),
        .update_i  (update),
        .c_i       (c),
        .pcin_i    (pcin),
        .p_o       (p),
        .pattern_o (pattern)
    );

    dsp_checker u_checker (
        .clk_i            (clk),
        .rst_n_i          (rst_n),
        .a_i              (a),
        .d_i              (d),
        .b_i              (b),
        .load_i           (load),
        .update_i         (update),
        .c_i              (c),
        .pcin_i           (pcin),
        .p_i              (p),
        .pattern_i        (pattern),
        .report_i         (report),
        .p_errors_o       (p_errors),
        .pattern_errors_o (pattern_errors),
        .checks_o         (checks)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus for one cycle chosen by phase
    ////////////////////////////////////////////////////////////////////////////

    task automatic drive_cycle(input int cycle);
        logic [31:0] r_a;
        logic [31:0] r_d;
        logic [31:0] r_b;
        logic [31:0] r_ctl;
        logic [63:0] r_c;
        logic [63:0] r_pcin;
        r_a    = $urandom();
        r_d    = $urandom();
        r_b    = $urandom();
        r_ctl  = $urandom();
        r_c    = {$urandom(), $urandom()};
        r_pcin = {$urandom(), $urandom()};
        a      <= r_a[A_W-1:0];
        d      <= r_d[A_W-1:0];
        b      <= r_b[B_W-1:0];
        c      <= r_c[P_W-1:0];
        pcin   <= r_pcin[P_W-1:0];
        // Load one in four, update one in eight
        load   <= (r_ctl[1:0] == 2'b00);
        update <= (r_ctl[4:2] == 3'b000);
        if (cycle < ZERO_END) begin
            a      <= '0;
            d      <= '0;
            b      <= '0;
            c      <= '0;
            pcin   <= '0;
            load   <= 1'b0;
            update <= 1'b0;
        end else if (cycle < COEF_END) begin
            // Load alone, update alone, both together, then update again
            load   <= (cycle == 16) || (cycle == 28);
            update <= (cycle == 22) || (cycle == 28) || (cycle == 34);
        end else if (cycle >= EXTREME_START && cycle < EXTREME_END) begin
            a <= r_a[0] ? A_MAX : A_MIN;
            d <= r_d[0] ? A_MAX : A_MIN;
            if (r_b[31:30] == 2'b00) begin
                b <= B_MAX;
            end else if (r_b[31:30] == 2'b01) begin
                b <= B_MIN;
            end
        end else if (cycle >= EXTREME_END && cycle < QUIET_END) begin
            // P follows PCIN alone, mostly with the compared nibble cleared
            a <= '0;
            d <= '0;
            c <= '0;
            if (r_ctl[7:6] != 2'b00) begin
                pcin <= {r_pcin[P_W-1:4], 4'h0};
            end
        end
    endtask

    initial begin
        void'($urandom(SEED));
        clk    = 1'b0;
        rst_n  = 1'b0;
        a      = '0;
        d      = '0;
        b      = '0;
        load   = 1'b0;
        update = 1'b0;
        c      = '0;
        pcin   = '0;
        report = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        for (int cycle = 0; cycle < NUM_CYCLES; cycle++) begin
            drive_cycle(cycle);
            @(posedge clk);
        end
        // Let the last samples drain through to P
        repeat (PIPE_AD) @(posedge clk);
        @(negedge clk);
        #1;
        report = 1'b1;
        #1;
        if (p_errors == 0 && pattern_errors == 0 && checks > 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, the run did not finish", cycle_count);
            $display("Verification failed");
            $finish;
        end
    end

endmodule

// File: filelist.f
source/dsp_width_pkg.sv
source/dsp_cfg_pkg.sv
source/product_path.sv
source/addend_path.sv
source/post_adder.sv
source/dsp_slice_top.sv
tb/dsp_checker.sv
tb/tb_dsp_slice.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the DSP slice testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary -j 0 --timescale 1ns/1ps --top-module tb_dsp_slice \
    -f filelist.f -o sim_dsp_slice > build.log 2>&1 \
    && ./obj_dir/sim_dsp_slice > sim.log 2>&1 \
    || { cat build.log sim.log 2>/dev/null; echo "Build or run error"; exit 1; }

cat sim.log

# The run passes only if the log holds the pass line
grep -qx "Verification passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
